// File: Bender.yml
package:
  name: video_encoder

sources:
  - files:
      - common/raster_pkg.sv
      - common/chroma_pkg.sv
      - design/raster_counter.sv
      - comp_sync/sync_decoder.sv
      - comp_sync/luma_gen.sv
      - comp_sync/chroma_gen.sv
      - comp_sync/sine_rom.sv
      - design/video_encoder_top.sv
  - target: test
    files:
      - verif/tb_clock_gen.sv
      - verif/tb_video_encoder.sv

// File: common/chroma_pkg.sv
`default_nettype none

package chroma_pkg;

    typedef struct packed {
        logic [5:0] luma;
        logic [7:0] phase;          // 256 steps per colour period
        logic [3:0] amplitude;      // 0 means no modulation
    } pixel_t;

    // composite luma levels
    localparam logic [5:0] BLANK_LEVEL_NTSC = 6'h18;
    localparam logic [5:0] BLANK_LEVEL_PAL  = 6'h08;
    localparam logic [5:0] SYNC_LEVEL       = 6'd0;
    localparam logic [5:0] WHITE_BURST      = 6'h3b;   // first visible pixel on white lines
    localparam logic [5:0] CHROMA_ZERO      = 6'd32;   // top six bits of the 256 midpoint

    // colour burst, 9 subcarrier periods of 16 samples
    localparam logic [3:0] BURST_AMPLITUDE    = 4'd12;
    localparam int         BURST_SAMPLES      = 144;
    localparam logic [9:0] BURST_START_NTSC   = 10'd50;
    localparam logic [9:0] BURST_START_PAL    = 10'd49;
    localparam logic [7:0] BURST_PHASE_NTSC     = 8'd128;  // 180 degrees
    localparam logic [7:0] BURST_PHASE_PAL_EVEN = 8'd96;   // 135 degrees
    localparam logic [7:0] BURST_PHASE_PAL_ODD  = 8'd160;  // -135 degrees

    localparam int SINE_ENTRIES   = 64;    // quarter wave samples
    localparam int AMP_FULL_SCALE = 15;

    typedef enum logic [1:0] {
        BURST_WAIT,
        BURST_ON,
        BURST_DONE
    } burst_state_t;

    function automatic logic [5:0] blank_level(logic pal);
        return pal ? BLANK_LEVEL_PAL : BLANK_LEVEL_NTSC;
    endfunction

endpackage

`default_nettype wire

// File: common/raster_pkg.sv
`default_nettype none

package raster_pkg;

    // model codes as the chip id register reports them
    typedef enum logic [1:0] {
        CHIP_6567R8   = 2'd0,
        CHIP_6567R56A = 2'd1,
        CHIP_6569R1   = 2'd2,
        CHIP_6569R3   = 2'd3
    } chip_model_t;

    localparam int DOT_DIV = 8;     // col16x cycles per raster_x step

    typedef struct packed {
        logic [9:0] x;
        logic [8:0] y;
        logic       tick;           // first cycle of a new x
    } raster_pos_t;

    typedef struct packed {
        logic hsync;
        logic vsync;
        logic active;
        logic pulse_low;            // eq or serration low phase in vblank
    } sync_state_t;

    // frame geometry
    localparam logic [8:0] NTSC_LINES = 9'd263;
    localparam logic [9:0] NTSC_WIDTH = 10'd520;
    localparam logic [8:0] PAL_LINES  = 9'd312;
    localparam logic [9:0] PAL_WIDTH  = 10'd504;

    // horizontal timing in raster_x units
    localparam logic [9:0] NTSC_HSYNC_START    = 10'd8;   // ~1us after line start
    localparam logic [9:0] NTSC_HSYNC_END      = 10'd45;  // ~4.5us sync tip
    localparam logic [9:0] NTSC_HVISIBLE_START = 10'd96;
    localparam logic [9:0] PAL_HSYNC_START     = 10'd7;
    localparam logic [9:0] PAL_HSYNC_END       = 10'd44;
    localparam logic [9:0] PAL_HVISIBLE_START  = 10'd91;

    // vertical timing in lines
    localparam logic [8:0] NTSC_VVISIBLE_END   = 9'd13;
    localparam logic [8:0] NTSC_VBLANK_START   = 9'd14;
    localparam logic [8:0] NTSC_VBLANK_END     = 9'd22;   // nine blanking lines
    localparam logic [8:0] NTSC_VVISIBLE_START = 9'd23;
    localparam logic [8:0] PAL_VVISIBLE_END    = 9'd300;
    localparam logic [8:0] PAL_VBLANK_START    = 9'd301;
    localparam logic [8:0] PAL_VBLANK_END      = 9'd309;
    localparam logic [8:0] PAL_VVISIBLE_START  = 9'd310;

    localparam logic [9:0] EQ_WIDTH = 10'd18;   // eq pulse low width
    localparam logic [9:0] SE_HIGH  = 10'd37;   // serration high width

    function automatic logic is_pal(chip_model_t c);
        return (c == CHIP_6569R1) || (c == CHIP_6569R3);
    endfunction

    function automatic logic [9:0] line_width(chip_model_t c);
        return is_pal(c) ? PAL_WIDTH : NTSC_WIDTH;
    endfunction

    function automatic logic [8:0] line_count(chip_model_t c);
        return is_pal(c) ? PAL_LINES : NTSC_LINES;
    endfunction

    function automatic logic [9:0] hsync_start(chip_model_t c);
        return is_pal(c) ? PAL_HSYNC_START : NTSC_HSYNC_START;
    endfunction

    function automatic logic [9:0] hsync_end(chip_model_t c);
        return is_pal(c) ? PAL_HSYNC_END : NTSC_HSYNC_END;
    endfunction

    function automatic logic [9:0] hvisible_start(chip_model_t c);
        return is_pal(c) ? PAL_HVISIBLE_START : NTSC_HVISIBLE_START;
    endfunction

    function automatic logic [8:0] vvisible_end(chip_model_t c);
        return is_pal(c) ? PAL_VVISIBLE_END : NTSC_VVISIBLE_END;
    endfunction

    function automatic logic [8:0] vblank_start(chip_model_t c);
        return is_pal(c) ? PAL_VBLANK_START : NTSC_VBLANK_START;
    endfunction

    function automatic logic [8:0] vblank_end(chip_model_t c);
        return is_pal(c) ? PAL_VBLANK_END : NTSC_VBLANK_END;
    endfunction

    function automatic logic [8:0] vvisible_start(chip_model_t c);
        return is_pal(c) ? PAL_VVISIBLE_START : NTSC_VVISIBLE_START;
    endfunction

endpackage

`default_nettype wire

// File: comp_sync/chroma_gen.sv
`timescale 1ns/1ps
`default_nettype none

module chroma_gen (
    input  wire logic                    clk_col16x,
    input  wire logic                    reset,
    input  wire raster_pkg::chip_model_t chip,
    input  wire raster_pkg::raster_pos_t pos,
    input  wire raster_pkg::sync_state_t sync,
    input  wire chroma_pkg::pixel_t      pix,
    input  wire logic                    white_line,
    output logic [11:0]                  rom_addr,
    input  wire logic [8:0]              rom_data,
    output logic [5:0]                   chroma_out
);
    import raster_pkg::*;
    import chroma_pkg::*;

    raster_pos_t  pos_q;        // aligned with sync
    logic [8:0]   prev_y;
    logic         new_line;
    logic [3:0]   phase_cnt;    // one subcarrier period per wrap
    burst_state_t burst_state;
    logic [7:0]   burst_cnt;
    logic         pal;
    logic         odd_line;
    logic         first_pix;
    logic [9:0]   burst_start;
    logic [3:0]   amp;
    logic [3:0]   amp_d1;       // matches the address register
    logic [3:0]   amp_d2;       // matches the rom output register
    logic [7:0]   offset;
    logic [7:0]   wave_addr;

    always_ff @(posedge clk_col16x) begin
        pos_q  <= pos;
        prev_y <= pos_q.y;
    end

    always_comb begin
        pal         = is_pal(chip);
        odd_line    = pos_q.y[0];
        new_line    = (pos_q.y != prev_y);
        first_pix   = white_line && (pos_q.x == hvisible_start(chip));
        burst_start = pal ? BURST_START_PAL : BURST_START_NTSC;
    end

    always_ff @(posedge clk_col16x) begin
        if (reset) begin
            burst_state <= BURST_WAIT;
            burst_cnt   <= '0;
        end else if (new_line) begin
            burst_state <= BURST_WAIT;          // re-arm every line
            burst_cnt   <= '0;
        end else begin
            case (burst_state)
                BURST_WAIT: if (pos_q.x >= burst_start) burst_state <= BURST_ON;
                BURST_ON: begin
                    if (burst_cnt == 8'(BURST_SAMPLES - 1)) begin
                        burst_state <= BURST_DONE;
                        burst_cnt   <= '0;
                    end else begin
                        burst_cnt   <= burst_cnt + 8'd1;
                    end
                end
                default: burst_state <= BURST_DONE;     // hold until next line
            endcase
        end
    end

    always_comb begin
        if (sync.vsync)
            amp = 4'd0;
        else if (sync.active)
            amp = first_pix ? 4'd0 : pix.amplitude;
        else if (burst_state == BURST_ON)
            amp = BURST_AMPLITUDE;
        else
            amp = 4'd0;

        // pal swings the v axis on odd lines
        if (sync.active)
            offset = (pal && odd_line) ? 8'd255 - pix.phase : pix.phase;
        else if (pal)
            offset = odd_line ? BURST_PHASE_PAL_ODD : BURST_PHASE_PAL_EVEN;
        else
            offset = BURST_PHASE_NTSC;

        wave_addr = {phase_cnt, 4'b0000} + offset;      // 16 samples per period
    end

    always_ff @(posedge clk_col16x)
        rom_addr <= {amp, wave_addr};   // amplitude selects the scaled table

    always_ff @(posedge clk_col16x) begin
        if (reset) begin
            phase_cnt  <= '0;
            amp_d1     <= '0;
            amp_d2     <= '0;
            chroma_out <= CHROMA_ZERO;
        end else begin
            phase_cnt  <= phase_cnt + 4'd1;
            amp_d1     <= amp;
            amp_d2     <= amp_d1;
            chroma_out <= (amp_d2 == 4'd0) ? CHROMA_ZERO : rom_data[8:3];
        end
    end

endmodule

`default_nettype wire

// File: comp_sync/luma_gen.sv
`timescale 1ns/1ps
`default_nettype none

module luma_gen (
    input  wire logic                    clk_col16x,
    input  wire logic                    reset,
    input  wire raster_pkg::chip_model_t chip,
    input  wire raster_pkg::raster_pos_t pos,
    input  wire raster_pkg::sync_state_t sync,
    input  wire chroma_pkg::pixel_t      pix,
    input  wire logic                    white_line,
    output logic [5:0]                   luma_out
);
    import raster_pkg::*;
    import chroma_pkg::*;

    raster_pos_t pos_q;         // lines up with the registered sync state
    logic        vb_lines;
    logic [5:0]  blank;
    logic [5:0]  luma_nxt;

    always_ff @(posedge clk_col16x)
        pos_q <= pos;

    always_comb begin
        blank    = blank_level(is_pal(chip));
        vb_lines = (pos_q.y >= vblank_start(chip)) && (pos_q.y <= vblank_end(chip));
        if (vb_lines)
            luma_nxt = sync.pulse_low ? SYNC_LEVEL : blank;   // eq / serration
        else if (sync.hsync)
            luma_nxt = SYNC_LEVEL;
        else if (!sync.active)
            luma_nxt = blank;
        else if (white_line && pos_q.x == hvisible_start(chip))
            luma_nxt = WHITE_BURST;     // off screen on a CRT, seen by upscalers
        else
            luma_nxt = pix.luma;
    end

    always_ff @(posedge clk_col16x) begin
        if (reset)
            luma_out <= SYNC_LEVEL;
        else
            luma_out <= luma_nxt;
    end

endmodule

`default_nettype wire

// File: comp_sync/sine_rom.sv
`timescale 1ns/1ps
`default_nettype none

module sine_rom (
    input  wire logic        clk_col16x,
    input  wire logic [11:0] addr,      // amplitude, then 8 bit phase
    output logic [8:0]       data
);
    import chroma_pkg::*;

    localparam int HALF_TURN = 4 * SINE_ENTRIES;   // in half-sample steps

    typedef logic [7:0] quarter_t [SINE_ENTRIES];

    // integer sine approximation over the first quadrant, sampled at bin centres
    function automatic quarter_t make_quarter();
        quarter_t t;
        int       k;
        int       num;
        int       den;
        for (int i = 0; i < SINE_ENTRIES; i++) begin
            k    = 2 * i + 1;
            num  = 16 * k * (HALF_TURN - k);
            den  = 5 * HALF_TURN * HALF_TURN - 4 * k * (HALF_TURN - k);
            t[i] = 8'((255 * num + den / 2) / den);     // full scale 255
        end
        return t;
    endfunction

    localparam quarter_t QUARTER = make_quarter();

    logic [1:0]  quad;
    logic [5:0]  idx;
    logic [7:0]  mag;
    logic [11:0] product;
    logic [7:0]  scaled;

    always_comb begin
        quad    = addr[7:6];
        idx     = quad[0] ? ~addr[5:0] : addr[5:0];     // falling quarters mirror
        mag     = QUARTER[idx];
        product = mag * addr[11:8];
        scaled  = 8'(product / AMP_FULL_SCALE);
    end

    always_ff @(posedge clk_col16x)
        data <= quad[1] ? 9'd256 - scaled : 9'd256 + scaled;   // negative half below 256

endmodule

`default_nettype wire

// File: comp_sync/sync_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module sync_decoder (
    input  wire logic                    clk_col16x,
    input  wire logic                    reset,
    input  wire raster_pkg::chip_model_t chip,
    input  wire raster_pkg::raster_pos_t pos,
    output raster_pkg::sync_state_t      sync
);
    import raster_pkg::*;

    logic [9:0] half;           // half line width
    logic [9:0] hx;             // x within the current half line
    logic [3:0] vb_line;        // index into the nine blanking lines
    logic       in_vb;
    logic       eq_low;
    logic       se_low;
    logic       hsync_n;
    logic       vsync_n;
    logic       hblank;
    logic       vblank;

    always_comb begin
        half    = line_width(chip) >> 1;
        hx      = (pos.x >= half) ? pos.x - half : pos.x;
        vb_line = 4'(pos.y - vblank_start(chip));
        in_vb   = (pos.y >= vblank_start(chip)) && (pos.y <= vblank_end(chip));

        eq_low = (hx < EQ_WIDTH);               // short low at start of half line
        se_low = (hx < half - SE_HIGH);         // long low, high only at the end

        hsync_n = (pos.x >= hsync_start(chip)) && (pos.x < hsync_end(chip));

        // vsync runs from hsync on the first blank line to hsync end on the last
        vsync_n = ((pos.y == vblank_start(chip) && pos.x >= hsync_start(chip)) ||
                   (pos.y > vblank_start(chip))) &&
                  ((pos.y < vblank_end(chip)) ||
                   (pos.y == vblank_end(chip) && pos.x < hsync_end(chip)));

        hblank = (pos.x < hvisible_start(chip));
        vblank = (pos.y >= vvisible_end(chip)) &&
                 ((pos.y < vvisible_start(chip)) ||
                  (pos.y == vvisible_start(chip) && pos.x <= hvisible_start(chip)));
    end

    always_ff @(posedge clk_col16x) begin
        if (reset) begin
            sync <= '0;
        end else begin
            sync.hsync  <= hsync_n;
            sync.vsync  <= vsync_n;
            sync.active <= !hblank && !vblank;
            // lines 3 to 5 serrate, the rest equalize
            if (in_vb && vb_line >= 4'd3 && vb_line <= 4'd5)
                sync.pulse_low <= se_low;
            else
                sync.pulse_low <= in_vb && eq_low;
        end
    end

endmodule

`default_nettype wire

// File: design/raster_counter.sv
`timescale 1ns/1ps
`default_nettype none

module raster_counter (
    input  wire logic                    clk_col16x,
    input  wire logic                    reset,
    input  wire raster_pkg::chip_model_t chip,
    output raster_pkg::raster_pos_t      pos
);
    import raster_pkg::*;

    localparam int DIV_W = $clog2(DOT_DIV);

    logic [DIV_W-1:0] div_cnt;
    logic             step;         // last col16x cycle of this x
    logic             last_x;
    logic             last_y;

    assign step   = (div_cnt == DIV_W'(DOT_DIV - 1));
    assign last_x = (pos.x == line_width(chip) - 10'd1);
    assign last_y = (pos.y == line_count(chip) - 9'd1);

    always_ff @(posedge clk_col16x) begin
        if (reset) begin
            div_cnt  <= '0;
            pos      <= '0;
        end else begin
            div_cnt  <= step ? '0 : div_cnt + 1'b1;
            pos.tick <= step;   // marks the cycle the new x appears
            if (step) begin
                if (last_x) begin
                    pos.x <= '0;
                    pos.y <= last_y ? '0 : pos.y + 9'd1;    // next line on wrap
                end else begin
                    pos.x <= pos.x + 10'd1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: design/video_encoder_top.sv
`timescale 1ns/1ps
`default_nettype none

module video_encoder_top (
    input  wire logic                    clk_col16x,
    input  wire logic                    reset,
    input  wire raster_pkg::chip_model_t chip,
    input  wire chroma_pkg::pixel_t      pixel,
    input  wire logic                    pixel_valid,
    input  wire logic                    white_line,
    output logic                         pixel_ready,
    output logic [9:0]                   raster_x,
    output logic [8:0]                   raster_y,
    output logic [5:0]                   luma_out,
    output logic [5:0]                   chroma_out
);
    import raster_pkg::*;
    import chroma_pkg::*;

    raster_pos_t pos;
    sync_state_t sync;
    logic        tick_q;        // tick delayed to meet the sync state
    pixel_t      pix_in;        // offered pixel or underrun black
    pixel_t      pix_acc;       // held for the rest of the dot
    pixel_t      pix_cur;
    logic [11:0] rom_addr;
    logic [8:0]  rom_data;

    raster_counter u_raster (.clk_col16x, .reset, .chip, .pos);
    sync_decoder   u_sync   (.clk_col16x, .reset, .chip, .pos, .sync);

    always_ff @(posedge clk_col16x) begin
        if (reset)
            tick_q <= 1'b0;
        else
            tick_q <= pos.tick;
    end

    assign pixel_ready = tick_q && sync.active;     // one pull per active dot

    always_comb begin
        pix_in = pixel;
        if (!pixel_valid) begin                     // underrun, show black
            pix_in.luma      = blank_level(is_pal(chip));
            pix_in.phase     = 8'd0;
            pix_in.amplitude = 4'd0;
        end
    end

    always_ff @(posedge clk_col16x)
        if (pixel_ready) pix_acc <= pix_in;

    assign pix_cur  = pixel_ready ? pix_in : pix_acc;
    assign raster_x = pos.x;
    assign raster_y = pos.y;

    luma_gen u_luma (
        .clk_col16x, .reset, .chip, .pos, .sync,
        .pix(pix_cur), .white_line, .luma_out
    );

    chroma_gen u_chroma (
        .clk_col16x, .reset, .chip, .pos, .sync,
        .pix(pix_cur), .white_line, .rom_addr, .rom_data, .chroma_out
    );

    sine_rom u_rom (.clk_col16x, .addr(rom_addr), .data(rom_data));

endmodule

`default_nettype wire

// File: verif/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter real PERIOD       = 8.0,
    parameter int  RESET_CYCLES = 10
) (
    output logic clk_col16x,
    output logic reset
);

    initial begin
        clk_col16x = 1'b0;
        forever #(PERIOD / 2.0) clk_col16x = ~clk_col16x;
    end

    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_col16x);
        reset <= 1'b0;      // released on the edge after the last reset cycle
    end

endmodule

`default_nettype wire

// File: verif/tb_video_encoder.sv
`timescale 1ns/1ps
`default_nettype none

module tb_video_encoder;
    import raster_pkg::*;
    import chroma_pkg::*;

    localparam int NUM_FIELDS     = 10;     // tokens per stimulus line
    localparam int MAX_CHECKS     = 64;
    localparam int WAIT_LIMIT     = 1400000;    // a bit over one PAL frame
    localparam int DRIVE_DELAY    = 1;
    localparam int CHROMA_SAMPLES = 8;      // one dot worth of col16x cycles
    localparam logic [31:0] NO_ENTRY = 32'hffffffff;

    logic        clk_col16x;
    logic        gen_reset;
    logic        restart;           // extra reset when the chip model changes
    logic        reset;
    chip_model_t chip;
    pixel_t      pixel;
    logic        pixel_valid;
    logic        white_line;
    logic        pixel_ready;
    logic [9:0]  raster_x;
    logic [8:0]  raster_y;
    logic [5:0]  luma_out;
    logic [5:0]  chroma_out;

    logic [31:0] stim [0:MAX_CHECKS*NUM_FIELDS-1];
    int          errors;
    int          checks;
    int          cyc;               // tracks the free running phase counter
    int          ready_cnt;
    int          dot_cycles;        // col16x cycles seen on the current dot
    int          exp_x;
    int          exp_y;
    logic [9:0]  mon_x;
    logic [8:0]  mon_y;
    logic        timed_out;

    assign reset = gen_reset | restart;

    tb_clock_gen #(.PERIOD(8.0), .RESET_CYCLES(10)) u_clk (
        .clk_col16x, .reset(gen_reset)
    );

    video_encoder_top UUT (
        .clk_col16x, .reset, .chip, .pixel, .pixel_valid, .white_line,
        .pixel_ready, .raster_x, .raster_y, .luma_out, .chroma_out
    );

    task automatic check_value(input string name, input int actual, input int expected,
                               input int tol);
        int diff;
        diff = actual - expected;
        if (diff < 0)
            diff = -diff;
        checks++;
        if (diff > tol) begin
            errors++;
            $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, actual, expected);
        end
    endtask

    function automatic logic chip_is_pal(chip_model_t c);
        return (c == CHIP_6569R1) || (c == CHIP_6569R3);
    endfunction

    // a dot takes a pixel when it lies right of hblank and outside the vertical blank
    function automatic logic active_dot(chip_model_t c, logic [9:0] x, logic [8:0] y);
        logic [9:0] hvs;
        logic [8:0] vend;
        logic [8:0] vstart;
        logic       vblank;
        hvs    = chip_is_pal(c) ? PAL_HVISIBLE_START : NTSC_HVISIBLE_START;
        vend   = chip_is_pal(c) ? PAL_VVISIBLE_END : NTSC_VVISIBLE_END;
        vstart = chip_is_pal(c) ? PAL_VVISIBLE_START : NTSC_VVISIBLE_START;
        vblank = (y >= vend) && ((y < vstart) || (y == vstart && x <= hvs));
        return (x >= hvs) && !vblank;
    endfunction

    // ideal sine sample, phase counter runs 3 cycles ahead of chroma_out
    function automatic int chroma_sample(int amp, int offset, int count);
        int  ph;
        real v;
        ph = ((((count - 3) & 15) * 16) + offset) & 255;
        v  = 256.0 + 255.0 * amp / 15.0 * $sin(2.0 * 3.14159265358979 * ph / 256.0);
        return int'($floor(v)) >>> 3;   // top six of nine bits
    endfunction

    function automatic int burst_offset(chip_model_t c, int y);
        if (!chip_is_pal(c))
            return BURST_PHASE_NTSC;
        return (y % 2 == 1) ? BURST_PHASE_PAL_ODD : BURST_PHASE_PAL_EVEN;
    endfunction

    task automatic next_cycle();
        @(posedge clk_col16x);
        #DRIVE_DELAY;
    endtask

    task automatic wait_position(input int x, input int y, output logic found);
        int n;
        found = 1'b0;
        n     = 0;
        while (!found && n < WAIT_LIMIT) begin
            next_cycle();
            if (raster_x == x && raster_y == y)
                found = 1'b1;
            n++;
        end
    endtask

    task automatic wait_reset_release(output logic found);
        int n;
        found = 1'b0;
        n     = 0;
        while (!found && n < 100) begin
            next_cycle();
            found = !reset;
            n++;
        end
    endtask

    task automatic run_entry(input int idx);
        int          base;
        int          x;
        int          y;
        int          cls;
        int          amp;
        int          offset;
        int          exp_c;
        int          tol;
        chip_model_t c;
        logic        found;
        base = idx * NUM_FIELDS;
        c    = chip_model_t'(stim[base][1:0]);
        x    = stim[base+1];
        y    = stim[base+2];
        cls  = stim[base+9];
        if (c != chip) begin
            chip    = c;        // new model only over a reset
            restart = 1'b1;
            repeat (10) next_cycle();
            restart = 1'b0;
        end
        pixel.luma      = stim[base+3][5:0];
        pixel.phase     = stim[base+4][7:0];
        pixel.amplitude = stim[base+5][3:0];
        pixel_valid     = stim[base+6][0];
        white_line      = stim[base+7][0];

        wait_position(x, y, found);
        if (!found) begin
            $display("timeout: raster never reached x=%0d y=%0d", x, y);
            errors++;
            timed_out = 1'b1;
            return;
        end
        repeat (2) next_cycle();    // luma trails the position by two cycles
        check_value($sformatf("luma_out x=%0d y=%0d", x, y), luma_out,
                    stim[base+8], 0);
        repeat (2) next_cycle();    // first chroma sample of this dot

        if (cls == 1) begin
            amp    = pixel.amplitude;
            offset = (chip_is_pal(chip) && y % 2 == 1) ? 255 - pixel.phase : pixel.phase;
        end else begin
            amp    = BURST_AMPLITUDE;
            offset = burst_offset(chip, y);
        end
        for (int i = 0; i < CHROMA_SAMPLES; i++) begin
            if (cls == 0) begin
                exp_c = CHROMA_ZERO;
                tol   = 0;
            end else begin
                exp_c = chroma_sample(amp, offset, cyc);
                tol   = 1;          // table rounding
            end
            check_value($sformatf("chroma_out x=%0d y=%0d sample %0d", x, y, i),
                        chroma_out, exp_c, tol);
            next_cycle();
        end
    endtask

    always @(posedge clk_col16x) begin
        if (reset)
            cyc <= 0;
        else
            cyc <= cyc + 1;
    end

    // one ready pulse on each active dot, none elsewhere
    // each dot lasts DOT_DIV cycles and steps to the next raster position
    always @(negedge clk_col16x) begin
        if (reset) begin
            ready_cnt  = 0;
            dot_cycles = 0;
            mon_x      = '0;
            mon_y      = '0;
        end else begin
            if (raster_x != mon_x || raster_y != mon_y) begin
                check_value("pixel_ready pulses per dot", ready_cnt,
                            active_dot(chip, mon_x, mon_y) ? 1 : 0, 0);
                check_value("dot length in cycles", dot_cycles, DOT_DIV, 0);
                exp_x = mon_x + 1;
                exp_y = mon_y;
                if (exp_x == (chip_is_pal(chip) ? PAL_WIDTH : NTSC_WIDTH)) begin
                    exp_x = 0;      // line wrap
                    exp_y = (mon_y + 1) % (chip_is_pal(chip) ? PAL_LINES : NTSC_LINES);
                end
                check_value("raster_x", raster_x, exp_x, 0);
                check_value("raster_y", raster_y, exp_y, 0);
                ready_cnt  = 0;
                dot_cycles = 0;
                mon_x      = raster_x;
                mon_y      = raster_y;
            end
            dot_cycles++;
            if (pixel_ready)
                ready_cnt++;
        end
    end

    initial begin
        int   idx;
        logic found;
        errors      = 0;
        checks      = 0;
        timed_out   = 1'b0;
        restart     = 1'b0;
        pixel       = '0;
        pixel_valid = 1'b0;
        white_line  = 1'b0;
        for (int i = 0; i < MAX_CHECKS * NUM_FIELDS; i++)
            stim[i] = NO_ENTRY;
        $readmemh("verif/video_stimulus.txt", stim);
        chip = chip_model_t'(stim[0][1:0]);

        wait_reset_release(found);
        if (!found) begin
            $display("timeout: reset was never released");
            errors++;
            timed_out = 1'b1;
        end
        idx = 0;
        while (!timed_out && idx < MAX_CHECKS && stim[idx*NUM_FIELDS] != NO_ENTRY) begin
            run_entry(idx);
            idx++;
        end
        if (idx == 0) begin
            $display("no stimulus entries were read");
            errors++;
        end

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0 && !timed_out)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: verif/video_stimulus.txt
// chip x y pix_luma pix_phase pix_amp valid white exp_luma chroma_class
// chroma_class 0 flat at zero, 1 pixel modulation, 2 colour burst
0 005 00e 00 00 0 1 0 00 0
0 01e 00e 00 00 0 1 0 18 0
0 109 00e 00 00 0 1 0 00 0
0 064 012 00 00 0 1 0 00 0
0 0f0 012 00 00 0 1 0 18 0
0 10e 012 00 00 0 1 0 00 0
0 014 015 00 00 0 1 0 18 0
0 004 032 00 00 0 1 0 18 0
0 014 032 00 00 0 1 0 00 0
0 02e 032 00 00 0 1 0 18 0
0 037 032 00 00 0 1 0 18 2
0 050 032 00 00 0 1 0 18 0
0 060 032 2a 40 9 1 1 3b 0
0 078 032 2a 40 9 1 0 2a 1
0 0c8 032 2a 40 9 0 0 18 0
0 12c 032 11 80 0 1 0 11 0
3 014 064 00 00 0 1 0 00 0
3 02d 064 00 00 0 1 0 08 0
3 036 064 00 00 0 1 0 08 2
3 096 064 25 30 7 1 0 25 1
3 036 065 00 00 0 1 0 08 2
3 096 065 25 30 7 1 0 25 1
3 0c8 065 25 30 7 0 0 08 0
3 00a 12e 00 00 0 1 0 00 0
3 0e6 131 00 00 0 1 0 08 0
3 104 131 00 00 0 1 0 00 0
3 12c 134 00 00 0 1 0 08 0

// File: video_encoder.f
common/raster_pkg.sv
common/chroma_pkg.sv
design/raster_counter.sv
comp_sync/sync_decoder.sv
comp_sync/luma_gen.sv
comp_sync/chroma_gen.sv
comp_sync/sine_rom.sv
design/video_encoder_top.sv
verif/tb_clock_gen.sv
verif/tb_video_encoder.sv
